/* hdl/soc_pkg.sv */
/*
 * Shared bus types, address map and ids for the peripheral bus fabric.
 * Addresses are word addresses. Every region base is aligned to its size.
 */
package soc_pkg;

	localparam int ARCH_W = 32;
	localparam int ADDR_W = 30;

	typedef logic [ARCH_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [ARCH_W/8-1:0] sel_t;

	// PerInt op encoding, read-modify-write left out
	typedef enum logic [1:0] {
		PI1_NOP   = 2'b00,
		PI1_WRITE = 2'b01,
		PI1_READ  = 2'b10
	} pi1_op_t;

	typedef struct packed {
		pi1_op_t op;
		addr_t   addr;
		word_t   data;
		sel_t    sel;
	} pi1_req_t;

	typedef struct packed {
		word_t data;
		logic  rdy;
	} pi1_rsp_t;

	localparam addr_t RAM_BASE     = 30'h0000;
	localparam addr_t RAM_WORDS    = 30'd1024;
	localparam addr_t DEVTBL_BASE  = 30'h4000;
	localparam addr_t DEVTBL_WORDS = 30'd16;
	localparam addr_t GPIO_BASE    = 30'h4100;
	localparam addr_t GPIO_WORDS   = 30'd2;
	localparam addr_t DMA_BASE     = 30'h4200;
	localparam addr_t DMA_WORDS    = 30'd4;
	localparam addr_t INTC_BASE    = 30'h4300;
	localparam addr_t INTC_WORDS   = 30'd2;

	// Slave indices, the invalid responder comes last
	localparam int SLV_RAM     = 0;
	localparam int SLV_DEVTBL  = 1;
	localparam int SLV_GPIO    = 2;
	localparam int SLV_DMA     = 3;
	localparam int SLV_INTC    = 4;
	localparam int SLV_INVALID = 5;
	localparam int SLV_COUNT   = 6;

	localparam word_t DEV_ID_RAM     = 32'd1;
	localparam word_t DEV_ID_DEVTBL  = 32'd7;
	localparam word_t DEV_ID_GPIO    = 32'd6;
	localparam word_t DEV_ID_DMA     = 32'd2;
	localparam word_t DEV_ID_INTC    = 32'd3;
	localparam word_t DEV_ID_INVALID = 32'd0;

	localparam logic MST_HOST = 1'b0;
	localparam logic MST_DMA  = 1'b1;

	localparam int IRQ_SRC_GPIO  = 0;
	localparam int IRQ_SRC_DMA   = 1;
	localparam int IRQ_SRC_COUNT = 2;
	typedef logic [IRQ_SRC_COUNT-1:0] irq_vec_t;

	localparam int GPIO_COUNT = 8;
	typedef logic [GPIO_COUNT-1:0] gpio_t;

	localparam word_t INTC_NONE = '1;

	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_WRITE
	} dma_state_t;

endpackage

/* hdl/ram_slave.sv */
/*
 * On-chip word RAM, no initial contents. Writes honor byte selects.
 */
module ram_slave (
	input  logic              clk200mhz_w,
	input  logic              rst_p,
	input  soc_pkg::pi1_req_t bus_req_i,
	output soc_pkg::pi1_rsp_t bus_rsp_o
);

	soc_pkg::word_t                         mem_q [soc_pkg::RAM_WORDS];
	soc_pkg::word_t                         rsp_data_q;
	logic [$clog2(soc_pkg::RAM_WORDS)-1:0]  idx_w;
	logic                                   rdy_q;
	logic                                   act_w;

	assign idx_w = bus_req_i.addr[$clog2(soc_pkg::RAM_WORDS)-1:0];
	assign act_w = bus_req_i.op != soc_pkg::PI1_NOP && !rdy_q;

	always_ff @(posedge clk200mhz_w) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= act_w;
	end

	always_ff @(posedge clk200mhz_w) begin
		if (act_w && bus_req_i.op == soc_pkg::PI1_WRITE) begin
			for (int b = 0; b < soc_pkg::ARCH_W / 8; b++) begin
				if (bus_req_i.sel[b])
					mem_q[idx_w][b*8 +: 8] <= bus_req_i.data[b*8 +: 8];
			end
		end
		if (act_w)
			rsp_data_q <= mem_q[idx_w];
	end

	assign bus_rsp_o = '{data: rsp_data_q, rdy: rdy_q};

endmodule

/* hdl/dev_table.sv */
/*
 * Read-only device table. Word i gives the id of slave i, word 8+i its size in words.
 * Writes complete and change nothing.
 */
module dev_table (
	input  logic              clk200mhz_w,
	input  logic              rst_p,
	input  soc_pkg::pi1_req_t bus_req_i,
	output soc_pkg::pi1_rsp_t bus_rsp_o
);

	soc_pkg::word_t id_w;
	soc_pkg::word_t size_w;
	soc_pkg::word_t rsp_data_q;
	logic [3:0]     off_w;
	logic           rdy_q;
	logic           act_w;

	assign off_w = bus_req_i.addr[3:0];
	assign act_w = bus_req_i.op != soc_pkg::PI1_NOP && !rdy_q;

	always_comb begin
		case (off_w[2:0])
			3'(soc_pkg::SLV_RAM): begin
				id_w   = soc_pkg::DEV_ID_RAM;
				size_w = soc_pkg::word_t'(soc_pkg::RAM_WORDS);
			end
			3'(soc_pkg::SLV_DEVTBL): begin
				id_w   = soc_pkg::DEV_ID_DEVTBL;
				size_w = soc_pkg::word_t'(soc_pkg::DEVTBL_WORDS);
			end
			3'(soc_pkg::SLV_GPIO): begin
				id_w   = soc_pkg::DEV_ID_GPIO;
				size_w = soc_pkg::word_t'(soc_pkg::GPIO_WORDS);
			end
			3'(soc_pkg::SLV_DMA): begin
				id_w   = soc_pkg::DEV_ID_DMA;
				size_w = soc_pkg::word_t'(soc_pkg::DMA_WORDS);
			end
			3'(soc_pkg::SLV_INTC): begin
				id_w   = soc_pkg::DEV_ID_INTC;
				size_w = soc_pkg::word_t'(soc_pkg::INTC_WORDS);
			end
			// Invalid slave and unused entries
			default: begin
				id_w   = soc_pkg::DEV_ID_INVALID;
				size_w = '0;
			end
		endcase
	end

	always_ff @(posedge clk200mhz_w) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= act_w;
	end

	always_ff @(posedge clk200mhz_w) begin
		if (act_w)
			rsp_data_q <= off_w[3] ? size_w : id_w;
	end

	assign bus_rsp_o = '{data: rsp_data_q, rdy: rdy_q};

endmodule

/* hdl/gpio_port.sv */
/*
 * 8-bit GPIO. Word 0 reads sampled inputs, word 1 is the output register (byte 0 only).
 * Inputs are assumed synchronous to the bus clock.
 */
module gpio_port (
	input  logic              clk200mhz_w,
	input  logic              rst_p,
	input  soc_pkg::pi1_req_t bus_req_i,
	output soc_pkg::pi1_rsp_t bus_rsp_o,
	input  soc_pkg::gpio_t    gp_i,
	output soc_pkg::gpio_t    gp_o,
	output logic              irq_req_o,
	input  logic              irq_ack_i
);

	soc_pkg::gpio_t in_q;
	soc_pkg::gpio_t out_q;
	soc_pkg::word_t rsp_data_q;
	logic           rdy_q;
	logic           irq_q;
	logic           act_w;

	assign act_w = bus_req_i.op != soc_pkg::PI1_NOP && !rdy_q;

	always_ff @(posedge clk200mhz_w) begin
		if (rst_p) begin
			rdy_q <= 1'b0;
			irq_q <= 1'b0;
			out_q <= '0;
		end else begin
			rdy_q <= act_w;
			if (irq_ack_i)
				irq_q <= 1'b0;
			// A new sample that differs raises the request
			if (gp_i != in_q)
				irq_q <= 1'b1;
			if (act_w && bus_req_i.op == soc_pkg::PI1_WRITE && bus_req_i.addr[0]
					&& bus_req_i.sel[0])
				out_q <= bus_req_i.data[soc_pkg::GPIO_COUNT-1:0];
		end
	end

	always_ff @(posedge clk200mhz_w) begin
		in_q <= gp_i;
		if (act_w)
			rsp_data_q <= bus_req_i.addr[0] ? soc_pkg::word_t'(out_q) : soc_pkg::word_t'(in_q);
	end

	assign bus_rsp_o = '{data: rsp_data_q, rdy: rdy_q};
	assign gp_o      = out_q;
	assign irq_req_o = irq_q;

endmodule

/* hdl/int_ctrl.sv */
/*
 * Interrupt controller for one destination. Word 0 reads the lowest pending source or
 * all ones, word 1 the pending mask. Bus writes complete without effect.
 */
module int_ctrl (
	input  logic              clk200mhz_w,
	input  logic              rst_p,
	input  soc_pkg::pi1_req_t bus_req_i,
	output soc_pkg::pi1_rsp_t bus_rsp_o,
	input  soc_pkg::irq_vec_t src_req_i,
	output soc_pkg::irq_vec_t src_ack_o,
	output logic              irq_o,
	input  logic              irq_ack_i
);

	soc_pkg::irq_vec_t pend_q;
	soc_pkg::irq_vec_t low_hot_w;
	soc_pkg::irq_vec_t ack_w;
	soc_pkg::word_t    low_idx_w;
	soc_pkg::word_t    rsp_data_q;
	logic              rdy_q;
	logic              act_w;

	assign act_w = bus_req_i.op != soc_pkg::PI1_NOP && !rdy_q;

	// Isolate lowest set bit
	assign low_hot_w = pend_q & (~pend_q + 1'b1);
	assign ack_w     = irq_ack_i ? low_hot_w : '0;

	always_comb begin
		low_idx_w = soc_pkg::INTC_NONE;
		for (int i = soc_pkg::IRQ_SRC_COUNT - 1; i >= 0; i--) begin
			if (pend_q[i])
				low_idx_w = soc_pkg::word_t'(i);
		end
	end

	always_ff @(posedge clk200mhz_w) begin
		if (rst_p) begin
			pend_q <= '0;
			rdy_q  <= 1'b0;
		end else begin
			// Acked source drops its level on this same edge
			pend_q <= (pend_q | src_req_i) & ~ack_w;
			rdy_q  <= act_w;
		end
	end

	always_ff @(posedge clk200mhz_w) begin
		if (act_w)
			rsp_data_q <= bus_req_i.addr[0] ? soc_pkg::word_t'(pend_q) : low_idx_w;
	end

	assign bus_rsp_o = '{data: rsp_data_q, rdy: rdy_q};
	assign src_ack_o = ack_w;
	assign irq_o     = |pend_q;

endmodule

/* hdl/dma_engine.sv */
/*
 * One-channel word copy engine. Registers take whole words and ignore byte selects.
 * Register writes are dropped while a copy runs. Status bit 0 is busy, bit 1 the irq.
 */
module dma_engine (
	input  logic              clk200mhz_w,
	input  logic              rst_p,
	input  soc_pkg::pi1_req_t cfg_req_i,
	output soc_pkg::pi1_rsp_t cfg_rsp_o,
	output soc_pkg::pi1_req_t mst_req_o,
	input  soc_pkg::pi1_rsp_t mst_rsp_i,
	output logic              irq_req_o,
	input  logic              irq_ack_i
);

	soc_pkg::dma_state_t state_q;
	soc_pkg::addr_t      src_q;
	soc_pkg::addr_t      dst_q;
	soc_pkg::word_t      cnt_q;
	soc_pkg::word_t      buf_q;
	soc_pkg::word_t      rsp_data_q;
	soc_pkg::word_t      rd_w;
	logic                rdy_q;
	logic                irq_q;
	logic                act_w;
	logic                wr_w;
	logic [1:0]          off_w;

	assign off_w = cfg_req_i.addr[1:0];
	assign act_w = cfg_req_i.op != soc_pkg::PI1_NOP && !rdy_q;
	assign wr_w  = act_w && cfg_req_i.op == soc_pkg::PI1_WRITE
		&& state_q == soc_pkg::DMA_IDLE;

	always_comb begin
		case (off_w)
			2'd0:    rd_w = soc_pkg::word_t'(src_q);
			2'd1:    rd_w = soc_pkg::word_t'(dst_q);
			2'd2:    rd_w = cnt_q;
			default: rd_w = {30'd0, irq_q, state_q != soc_pkg::DMA_IDLE};
		endcase
	end

	// Master side, the op is held straight from the state register
	always_comb begin
		mst_req_o = '0;
		if (state_q == soc_pkg::DMA_READ) begin
			mst_req_o.op   = soc_pkg::PI1_READ;
			mst_req_o.addr = src_q;
			mst_req_o.sel  = '1;
		end else if (state_q == soc_pkg::DMA_WRITE) begin
			mst_req_o.op   = soc_pkg::PI1_WRITE;
			mst_req_o.addr = dst_q;
			mst_req_o.data = buf_q;
			mst_req_o.sel  = '1;
		end
	end

	always_ff @(posedge clk200mhz_w) begin
		if (rst_p) begin
			state_q <= soc_pkg::DMA_IDLE;
			cnt_q   <= '0;
			irq_q   <= 1'b0;
			rdy_q   <= 1'b0;
		end else begin
			rdy_q <= act_w;
			if (irq_ack_i)
				irq_q <= 1'b0;
			case (state_q)
				soc_pkg::DMA_IDLE: begin
					// Writing the count starts the copy
					if (wr_w && off_w == 2'd2) begin
						cnt_q <= cfg_req_i.data;
						if (cfg_req_i.data != '0)
							state_q <= soc_pkg::DMA_READ;
					end
				end
				soc_pkg::DMA_READ: begin
					if (mst_rsp_i.rdy)
						state_q <= soc_pkg::DMA_WRITE;
				end
				soc_pkg::DMA_WRITE: begin
					if (mst_rsp_i.rdy) begin
						cnt_q <= cnt_q - 1'b1;
						if (cnt_q == 32'd1) begin
							state_q <= soc_pkg::DMA_IDLE;
							irq_q   <= 1'b1;
						end else begin
							state_q <= soc_pkg::DMA_READ;
						end
					end
				end
				default: state_q <= soc_pkg::DMA_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk200mhz_w) begin
		if (wr_w && off_w == 2'd0)
			src_q <= cfg_req_i.data[soc_pkg::ADDR_W-1:0];
		if (wr_w && off_w == 2'd1)
			dst_q <= cfg_req_i.data[soc_pkg::ADDR_W-1:0];
		if (state_q == soc_pkg::DMA_READ && mst_rsp_i.rdy)
			buf_q <= mst_rsp_i.data;
		if (state_q == soc_pkg::DMA_WRITE && mst_rsp_i.rdy) begin
			src_q <= src_q + 1'b1;
			dst_q <= dst_q + 1'b1;
		end
		if (act_w)
			rsp_data_q <= rd_w;
	end

	assign cfg_rsp_o = '{data: rsp_data_q, rdy: rdy_q};
	assign irq_req_o = irq_q;

endmodule

/* hdl/pi1_interconnect.sv */
/*
 * Two-master PerInt fabric with fixed host priority.
 * An access is locked one cycle after its op appears, so a free bus answers in 2 cycles.
 * Unmapped addresses go to a built-in responder that reads zero.
 */
module pi1_interconnect (
	input  logic               clk200mhz_w,
	input  logic               rst_p,
	input  soc_pkg::pi1_req_t  host_req_i,
	output soc_pkg::pi1_rsp_t  host_rsp_o,
	input  soc_pkg::pi1_req_t  dma_req_i,
	output soc_pkg::pi1_rsp_t  dma_rsp_o,
	output soc_pkg::pi1_req_t  slv_req_o [soc_pkg::SLV_COUNT-1],
	input  soc_pkg::pi1_rsp_t  slv_rsp_i [soc_pkg::SLV_COUNT-1]
);

	// Region hit, wrap of the subtraction rejects addresses below base
	function automatic logic in_region(input soc_pkg::addr_t a, input soc_pkg::addr_t base,
			input soc_pkg::addr_t words);
		return (a - base) < words;
	endfunction

	function automatic logic [$clog2(soc_pkg::SLV_COUNT)-1:0] decode_slave(
			input soc_pkg::addr_t a);
		if (in_region(a, soc_pkg::RAM_BASE, soc_pkg::RAM_WORDS))
			return 3'(soc_pkg::SLV_RAM);
		if (in_region(a, soc_pkg::DEVTBL_BASE, soc_pkg::DEVTBL_WORDS))
			return 3'(soc_pkg::SLV_DEVTBL);
		if (in_region(a, soc_pkg::GPIO_BASE, soc_pkg::GPIO_WORDS))
			return 3'(soc_pkg::SLV_GPIO);
		if (in_region(a, soc_pkg::DMA_BASE, soc_pkg::DMA_WORDS))
			return 3'(soc_pkg::SLV_DMA);
		if (in_region(a, soc_pkg::INTC_BASE, soc_pkg::INTC_WORDS))
			return 3'(soc_pkg::SLV_INTC);
		return 3'(soc_pkg::SLV_INVALID);
	endfunction

	logic                                  busy_q;
	logic                                  gnt_q;
	logic                                  inv_rdy_q;
	soc_pkg::pi1_req_t                     gnt_req_w;
	soc_pkg::pi1_rsp_t                     sel_rsp_w;
	logic [$clog2(soc_pkg::SLV_COUNT)-1:0] sel_w;

	assign gnt_req_w = (gnt_q == soc_pkg::MST_HOST) ? host_req_i : dma_req_i;
	assign sel_w = decode_slave(gnt_req_w.addr);

	// Only the decoded slave sees the op, and only once the access is locked
	always_comb begin
		for (int i = 0; i < soc_pkg::SLV_COUNT - 1; i++) begin
			slv_req_o[i] = gnt_req_w;
			if (!busy_q || sel_w != i)
				slv_req_o[i].op = soc_pkg::PI1_NOP;
		end
	end

	always_comb begin
		sel_rsp_w = '{data: '0, rdy: inv_rdy_q};
		if (sel_w != soc_pkg::SLV_INVALID)
			sel_rsp_w = slv_rsp_i[sel_w];
	end

	assign host_rsp_o = (gnt_q == soc_pkg::MST_HOST) ? sel_rsp_w : '0;
	assign dma_rsp_o  = (gnt_q == soc_pkg::MST_DMA) ? sel_rsp_w : '0;

	// Grant moves only while idle; host wins over DMA
	always_ff @(posedge clk200mhz_w) begin
		if (rst_p) begin
			busy_q <= 1'b0;
			gnt_q  <= soc_pkg::MST_HOST;
		end else if (!busy_q) begin
			if (host_req_i.op != soc_pkg::PI1_NOP) begin
				gnt_q  <= soc_pkg::MST_HOST;
				busy_q <= 1'b1;
			end else if (dma_req_i.op != soc_pkg::PI1_NOP) begin
				gnt_q  <= soc_pkg::MST_DMA;
				busy_q <= 1'b1;
			end
		end else if (sel_rsp_w.rdy) begin
			busy_q <= 1'b0;
		end
	end

	// Invalid device responder
	always_ff @(posedge clk200mhz_w) begin
		if (rst_p)
			inv_rdy_q <= 1'b0;
		else
			inv_rdy_q <= busy_q && sel_w == soc_pkg::SLV_INVALID
				&& gnt_req_w.op != soc_pkg::PI1_NOP && !inv_rdy_q;
	end

endmodule

/* hdl/soc_top.sv */
/*
 * Bus fabric top: host port and DMA share the bus to RAM, device table, GPIO, DMA
 * registers and interrupt controller. Single clock, synchronous reset.
 */
module soc_top (
	input  logic              clk200mhz_w,
	input  logic              rst_p,
	input  soc_pkg::pi1_req_t host_req_i,
	output soc_pkg::pi1_rsp_t host_rsp_o,
	input  soc_pkg::gpio_t    gp_i,
	output soc_pkg::gpio_t    gp_o,
	output logic              irq_o,
	input  logic              irq_ack_i
);

	soc_pkg::pi1_req_t dma_mst_req_w;
	soc_pkg::pi1_rsp_t dma_mst_rsp_w;
	soc_pkg::pi1_req_t slv_req_w [soc_pkg::SLV_COUNT-1];
	soc_pkg::pi1_rsp_t slv_rsp_w [soc_pkg::SLV_COUNT-1];
	soc_pkg::irq_vec_t src_req_w;
	soc_pkg::irq_vec_t src_ack_w;

	pi1_interconnect pi1_interconnect_inst (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.host_req_i  (host_req_i),
		.host_rsp_o  (host_rsp_o),
		.dma_req_i   (dma_mst_req_w),
		.dma_rsp_o   (dma_mst_rsp_w),
		.slv_req_o   (slv_req_w),
		.slv_rsp_i   (slv_rsp_w)
	);

	ram_slave ram_slave_inst (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.bus_req_i   (slv_req_w[soc_pkg::SLV_RAM]),
		.bus_rsp_o   (slv_rsp_w[soc_pkg::SLV_RAM])
	);

	dev_table dev_table_inst (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.bus_req_i   (slv_req_w[soc_pkg::SLV_DEVTBL]),
		.bus_rsp_o   (slv_rsp_w[soc_pkg::SLV_DEVTBL])
	);

	gpio_port gpio_port_inst (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.bus_req_i   (slv_req_w[soc_pkg::SLV_GPIO]),
		.bus_rsp_o   (slv_rsp_w[soc_pkg::SLV_GPIO]),
		.gp_i        (gp_i),
		.gp_o        (gp_o),
		.irq_req_o   (src_req_w[soc_pkg::IRQ_SRC_GPIO]),
		.irq_ack_i   (src_ack_w[soc_pkg::IRQ_SRC_GPIO])
	);

	dma_engine dma_engine_inst (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.cfg_req_i   (slv_req_w[soc_pkg::SLV_DMA]),
		.cfg_rsp_o   (slv_rsp_w[soc_pkg::SLV_DMA]),
		.mst_req_o   (dma_mst_req_w),
		.mst_rsp_i   (dma_mst_rsp_w),
		.irq_req_o   (src_req_w[soc_pkg::IRQ_SRC_DMA]),
		.irq_ack_i   (src_ack_w[soc_pkg::IRQ_SRC_DMA])
	);

	int_ctrl int_ctrl_inst (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.bus_req_i   (slv_req_w[soc_pkg::SLV_INTC]),
		.bus_rsp_o   (slv_rsp_w[soc_pkg::SLV_INTC]),
		.src_req_i   (src_req_w),
		.src_ack_o   (src_ack_w),
		.irq_o       (irq_o),
		.irq_ack_i   (irq_ack_i)
	);

endmodule

/* tests/pi1_bus_assert.sv */
/*
 * PerInt protocol properties, bound into pi1_interconnect.
 */
module pi1_bus_assert (
	input logic              clk200mhz_w,
	input logic              rst_p,
	input soc_pkg::pi1_req_t host_req_i,
	input soc_pkg::pi1_req_t dma_req_i,
	input soc_pkg::pi1_rsp_t host_rsp_i,
	input soc_pkg::pi1_rsp_t dma_rsp_i,
	input logic              busy_i,
	input soc_pkg::pi1_req_t gnt_req_i,
	input soc_pkg::pi1_rsp_t sel_rsp_i,
	input soc_pkg::pi1_rsp_t slv_rsp_i [soc_pkg::SLV_COUNT-1]
);

	int fail_count = 0;

	// A master sees rdy only while it holds a request
	rdy_to_requester: assert property (@(posedge clk200mhz_w) disable iff (rst_p)
		!(host_rsp_i.rdy && host_req_i.op == soc_pkg::PI1_NOP)
		&& !(dma_rsp_i.rdy && dma_req_i.op == soc_pkg::PI1_NOP))
		else begin
			fail_count++;
			$error("rdy reached a master that holds no request");
		end

	// A locked access keeps its request until rdy
	req_held: assert property (@(posedge clk200mhz_w) disable iff (rst_p)
		busy_i && !sel_rsp_i.rdy |=> $stable(gnt_req_i))
		else begin
			fail_count++;
			$error("granted request changed before rdy");
		end

	for (genvar i = 0; i < soc_pkg::SLV_COUNT - 1; i++) begin : g_slv
		slv_rdy_pulse: assert property (@(posedge clk200mhz_w) disable iff (rst_p)
			slv_rsp_i[i].rdy |=> !slv_rsp_i[i].rdy)
			else begin
				fail_count++;
				$error("slave %0d held rdy for more than one cycle", i);
			end
	end

endmodule

bind pi1_interconnect pi1_bus_assert pi1_bus_assert_inst (
	.clk200mhz_w (clk200mhz_w),
	.rst_p       (rst_p),
	.host_req_i  (host_req_i),
	.dma_req_i   (dma_req_i),
	.host_rsp_i  (host_rsp_o),
	.dma_rsp_i   (dma_rsp_o),
	.busy_i      (busy_q),
	.gnt_req_i   (gnt_req_w),
	.sel_rsp_i   (sel_rsp_w),
	.slv_rsp_i   (slv_rsp_i)
);

/* tests/soc_checker.sv */
/*
 * Result checker. A host access ends on rdy, a pin or irq step on step_i.
 * All values are sampled on the falling clock edge.
 */
module soc_checker (
	input  logic              clk200mhz_w,
	input  logic              rst_p,
	input  soc_pkg::pi1_req_t host_req_i,
	input  soc_pkg::pi1_rsp_t host_rsp_i,
	input  soc_pkg::gpio_t    gp_out_i,
	input  logic              irq_i,
	input  int                test_num_i,
	input  logic [1:0]        test_op_i,
	input  soc_pkg::word_t    exp_i,
	input  logic              step_i,
	output int                done_count_o,
	output int                error_count_o
);

	int done_q   = 0;
	int errors_q = 0;

	task automatic compare_value(input string name, input soc_pkg::word_t actual);
		done_q++;
		if (actual !== exp_i) begin
			errors_q++;
			$display("FAILED at %0t: test %0d, %s expected 0x%h, got 0x%h",
				$time, test_num_i, name, exp_i, actual);
		end else begin
			$display("test %0d ok: %s = 0x%h", test_num_i, name, actual);
		end
	endtask

	always @(negedge clk200mhz_w) begin
		if (!rst_p && host_req_i.op != soc_pkg::PI1_NOP && host_rsp_i.rdy) begin
			if (host_req_i.op == soc_pkg::PI1_READ) begin
				compare_value("host_rsp_o.data", host_rsp_i.data);
			end else begin
				done_q++;
				$display("test %0d ok: write to 0x%h done", test_num_i, host_req_i.addr);
			end
		end
		// Step code 3 is a pin step, anything else an irq check
		if (!rst_p && step_i) begin
			if (test_op_i == 2'd3)
				compare_value("gp_o", soc_pkg::word_t'(gp_out_i));
			else
				compare_value("irq_o", soc_pkg::word_t'(irq_i));
		end
	end

	assign done_count_o  = done_q;
	assign error_count_o = errors_q;

endmodule

/* tests/soc_tb.sv */
/*
 * Testbench for soc_top. Steps are read from tests/soc_tests.txt, so run from the project root.
 * A step is a host access, a GPIO pin step, or an irq check followed by an ack pulse.
 */
module soc_tb;

	localparam int    CLK_PERIOD      = 8;
	localparam int    RESET_CYCLES    = 5;
	localparam int    CYCLES_PER_TEST = 200;
	localparam string TEST_FILE       = "tests/soc_tests.txt";

	// Data file step codes match the bus op encoding for reads and writes
	localparam logic [1:0] OP_ACK   = 2'd0;
	localparam logic [1:0] OP_WRITE = 2'd1;
	localparam logic [1:0] OP_READ  = 2'd2;
	localparam logic [1:0] OP_PINS  = 2'd3;

	typedef struct packed {
		logic [1:0]     op;
		soc_pkg::addr_t addr;
		soc_pkg::word_t data;
		soc_pkg::sel_t  sel;
		soc_pkg::word_t exp;
		logic           wait_irq;
	} test_step_t;

	logic              clk200mhz_w;
	logic              rst_p;
	soc_pkg::pi1_req_t host_req;
	soc_pkg::pi1_rsp_t host_rsp;
	soc_pkg::gpio_t    gp_in;
	soc_pkg::gpio_t    gp_out;
	logic              irq;
	logic              irq_ack;
	int                test_num;
	logic [1:0]        test_op;
	soc_pkg::word_t    test_exp;
	logic              step;
	int                done_count;
	int                error_count;
	int                cycle_limit;
	logic              tests_loaded = 1'b0;
	test_step_t        steps [$];

	always #(CLK_PERIOD / 2) clk200mhz_w = ~clk200mhz_w;

	soc_top soc_top_inst (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.host_req_i  (host_req),
		.host_rsp_o  (host_rsp),
		.gp_i        (gp_in),
		.gp_o        (gp_out),
		.irq_o       (irq),
		.irq_ack_i   (irq_ack)
	);

	soc_checker soc_checker_inst (
		.clk200mhz_w   (clk200mhz_w),
		.rst_p         (rst_p),
		.host_req_i    (host_req),
		.host_rsp_i    (host_rsp),
		.gp_out_i      (gp_out),
		.irq_i         (irq),
		.test_num_i    (test_num),
		.test_op_i     (test_op),
		.exp_i         (test_exp),
		.step_i        (step),
		.done_count_o  (done_count),
		.error_count_o (error_count)
	);

	task automatic end_run(input logic failed);
		if (failed)
			$display("Simulation finished: FAIL");
		else
			$display("Simulation finished: PASS");
		$finish;
	endtask

	// Returns the number of steps read and skips comment and blank lines
	function automatic int load_tests();
		int             fd;
		int             op;
		int             wt;
		string          line;
		soc_pkg::word_t addr;
		soc_pkg::word_t data;
		soc_pkg::word_t sel;
		soc_pkg::word_t exp;
		test_step_t     s;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0)
			return 0;
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.substr(0, 1) == "//")
				continue;
			if ($sscanf(line, "%d %h %h %h %h %d", op, addr, data, sel, exp, wt) == 6) begin
				s.op       = op[1:0];
				s.addr     = addr[soc_pkg::ADDR_W-1:0];
				s.data     = data;
				s.sel      = sel[3:0];
				s.exp      = exp;
				s.wait_irq = wt != 0;
				steps.push_back(s);
			end
		end
		$fclose(fd);
		return steps.size();
	endfunction

	// Starts and ends one time unit after a rising edge
	task automatic run_step(input int num, input test_step_t s);
		if (s.wait_irq) begin
			do
				@(negedge clk200mhz_w);
			while (!irq);
			@(posedge clk200mhz_w);
			#1;
		end
		test_num = num;
		test_op  = s.op;
		test_exp = s.exp;
		case (s.op)
			OP_WRITE, OP_READ: begin
				host_req.op   = soc_pkg::pi1_op_t'(s.op);
				host_req.addr = s.addr;
				host_req.data = s.data;
				host_req.sel  = s.sel;
				// Request is held until the fabric answers
				do
					@(negedge clk200mhz_w);
				while (!host_rsp.rdy);
				@(posedge clk200mhz_w);
				#1;
				host_req = '0;
			end
			OP_PINS: begin
				gp_in = s.data[soc_pkg::GPIO_COUNT-1:0];
				step  = 1'b1;
				@(posedge clk200mhz_w);
				#1;
				step = 1'b0;
			end
			default: begin
				irq_ack = 1'b1;
				step    = 1'b1;
				@(posedge clk200mhz_w);
				#1;
				irq_ack = 1'b0;
				step    = 1'b0;
			end
		endcase
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		wait (tests_loaded);
		while (cycles < cycle_limit) begin
			@(posedge clk200mhz_w);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
		end_run(1'b1);
	end

	initial begin : main
		int   n_tests;
		int   assert_fails;
		logic failed;
		clk200mhz_w = 1'b0;
		rst_p       = 1'b1;
		host_req    = '0;
		gp_in       = '0;
		irq_ack     = 1'b0;
		test_num    = 0;
		test_op     = OP_ACK;
		test_exp    = '0;
		step        = 1'b0;
		n_tests = load_tests();
		if (n_tests == 0) begin
			$display("No test could be read from %s", TEST_FILE);
			end_run(1'b1);
		end else begin
			cycle_limit  = n_tests * CYCLES_PER_TEST;
			tests_loaded = 1'b1;
			repeat (RESET_CYCLES) @(posedge clk200mhz_w);
			#1;
			rst_p = 1'b0;
			foreach (steps[i])
				run_step(i + 1, steps[i]);
			repeat (2) @(posedge clk200mhz_w);
			assert_fails = soc_top_inst.pi1_interconnect_inst.pi1_bus_assert_inst.fail_count;
			if (done_count != n_tests)
				$display("Only %0d of %0d tests reported a result", done_count, n_tests);
			$display("Tests done: %0d of %0d, failed: %0d, assertion failures: %0d",
				done_count, n_tests, error_count, assert_fails);
			failed = error_count != 0 || done_count != n_tests || assert_fails != 0;
			end_run(failed);
		end
	end

endmodule

/* tests/soc_tests.txt */
// op addr data sel expected wait (all hex except op and wait)
// op 1 write, 2 read, 3 drive gp_i and check gp_o, 0 check irq_o then ack; wait 1 waits for irq_o
1 00000010 11223344 f 00000000 0
2 00000010 00000000 f 11223344 0
1 00000010 aabbccdd 5 00000000 0
2 00000010 00000000 f 11bb33dd 0
1 00000010 99000000 8 00000000 0
2 00000010 00000000 f 99bb33dd 0
// Device table ids and sizes
2 00004000 00000000 f 00000001 0
2 00004001 00000000 f 00000007 0
2 00004002 00000000 f 00000006 0
2 00004003 00000000 f 00000002 0
2 00004004 00000000 f 00000003 0
2 00004005 00000000 f 00000000 0
2 00004008 00000000 f 00000400 0
2 00004009 00000000 f 00000010 0
2 0000400a 00000000 f 00000002 0
2 0000400b 00000000 f 00000004 0
2 0000400c 00000000 f 00000002 0
// Unmapped address
1 00005000 12345678 f 00000000 0
2 00005000 00000000 f 00000000 0
// GPIO output, input change and its interrupt
1 00004101 000000a5 1 00000000 0
2 00004101 00000000 f 000000a5 0
3 00000000 0000003c 0 000000a5 0
2 00004300 00000000 f 00000000 1
0 00000000 00000000 0 00000001 1
2 00004300 00000000 f ffffffff 0
2 00004100 00000000 f 0000003c 0
// DMA copy of 4 words from 0x20 to 0x40
1 00000020 01010101 f 00000000 0
1 00000021 02020202 f 00000000 0
1 00000022 03030303 f 00000000 0
1 00000023 04040404 f 00000000 0
1 00004200 00000020 f 00000000 0
1 00004201 00000040 f 00000000 0
1 00004202 00000004 f 00000000 0
2 00004300 00000000 f 00000001 1
0 00000000 00000000 0 00000001 1
2 00004300 00000000 f ffffffff 0
2 00000040 00000000 f 01010101 0
2 00000041 00000000 f 02020202 0
2 00000042 00000000 f 03030303 0
2 00000043 00000000 f 04040404 0
// DMA copy to 0x60 with host traffic in between
1 00004200 00000020 f 00000000 0
1 00004201 00000060 f 00000000 0
1 00004202 00000004 f 00000000 0
2 00000010 00000000 f 99bb33dd 0
3 00000000 0000003c 0 000000a5 0
1 00000011 55aa55aa f 00000000 0
3 00000000 0000003c 0 000000a5 0
2 00000011 00000000 f 55aa55aa 0
2 00004101 00000000 f 000000a5 0
2 00004300 00000000 f 00000001 1
0 00000000 00000000 0 00000001 1
2 00000060 00000000 f 01010101 0
2 00000061 00000000 f 02020202 0
2 00000062 00000000 f 03030303 0
2 00000063 00000000 f 04040404 0

/* files.f */
hdl/soc_pkg.sv
hdl/ram_slave.sv
hdl/dev_table.sv
hdl/gpio_port.sv
hdl/int_ctrl.sv
hdl/dma_engine.sv
hdl/pi1_interconnect.sv
hdl/soc_top.sv
tests/pi1_bus_assert.sv
tests/soc_checker.sv
tests/soc_tb.sv

/* Bender.yml */
package:
  name: soc_fabric

sources:
  - hdl/soc_pkg.sv
  - hdl/ram_slave.sv
  - hdl/dev_table.sv
  - hdl/gpio_port.sv
  - hdl/int_ctrl.sv
  - hdl/dma_engine.sv
  - hdl/pi1_interconnect.sv
  - hdl/soc_top.sv
  - target: test
    files:
      - tests/pi1_bus_assert.sv
      - tests/soc_checker.sv
      - tests/soc_tb.sv
